/* id_pkg.sv */
/*
  Shared types and constants of the RV32I decode stage.
  Covers the base integer set only; no compressed, M or CSR encodings.
*/

package id_pkg;

  //////////////////////////////////////////////////
  // Widths
  //////////////////////////////////////////////////

  typedef logic [31:0] word_t;
  typedef logic [31:0] instr_t;
  typedef logic [4:0]  reg_addr_t;
  typedef logic [1:0]  lsu_type_t;

  // LSU access sizes
  localparam lsu_type_t LSU_WORD = 2'b00;
  localparam lsu_type_t LSU_HALF = 2'b01;
  localparam lsu_type_t LSU_BYTE = 2'b10;

  //////////////////////////////////////////////////
  // Major opcodes
  //////////////////////////////////////////////////

  localparam logic [6:0] OPC_OP     = 7'h33;
  localparam logic [6:0] OPC_OP_IMM = 7'h13;
  localparam logic [6:0] OPC_LOAD   = 7'h03;
  localparam logic [6:0] OPC_STORE  = 7'h23;
  localparam logic [6:0] OPC_BRANCH = 7'h63;
  localparam logic [6:0] OPC_JAL    = 7'h6f;
  localparam logic [6:0] OPC_JALR   = 7'h67;
  localparam logic [6:0] OPC_LUI    = 7'h37;
  localparam logic [6:0] OPC_AUIPC  = 7'h17;

  // Link offset and second-address step
  localparam word_t WORD_INCR = 32'd4;

  //////////////////////////////////////////////////
  // ALU operators and operand selects
  //////////////////////////////////////////////////

  typedef enum logic [3:0] {
    // Arithmetic and logic
    ALU_ADD, ALU_SUB, ALU_XOR, ALU_OR, ALU_AND,
    ALU_SLL, ALU_SRL, ALU_SRA, ALU_SLT, ALU_SLTU,
    // Branch comparisons
    ALU_EQ, ALU_NE, ALU_LT, ALU_GE, ALU_LTU, ALU_GEU
  } alu_op_e;

  typedef enum logic [1:0] {
    OP_A_REG_A,
    OP_A_LSU_ADDR,
    OP_A_CURRPC,
    OP_A_ZERO
  } op_a_sel_e;

  typedef enum logic {
    OP_B_REG_B,
    OP_B_IMM
  } op_b_sel_e;

  typedef enum logic [2:0] {
    IMM_B_I,
    IMM_B_S,
    IMM_B_B,
    IMM_B_U,
    IMM_B_J,
    IMM_B_INCR_PC,
    IMM_B_INCR_ADDR
  } imm_b_sel_e;

  // ID-EX state
  typedef enum logic {
    FIRST_CYCLE,
    MULTI_CYCLE
  } id_fsm_e;

endpackage

/* id_ctrl_if.sv */
/*
  Decoded control bundle shared by decoder, operand mux and ID-EX FSM.
  All fields are combinational within the current cycle.
*/

`timescale 1ns/1ps

interface id_ctrl_if import id_pkg::*; ();

  // ALU setup from the decoder
  alu_op_e    alu_operator;
  op_a_sel_e  op_a_sel;
  op_b_sel_e  op_b_sel;
  imm_b_sel_e imm_b_sel;

  // Sign-extended immediates
  word_t      imm_i;
  word_t      imm_s;
  word_t      imm_b;
  word_t      imm_u;
  word_t      imm_j;

  // Instruction class flags
  logic       lsu_req_dec;
  logic       branch_in_dec;
  logic       jump_in_dec;
  logic       rf_we_dec;

  // Valid instruction in its first cycle, from the FSM
  logic       instr_first_cycle;

  modport decoder (
    output alu_operator, op_a_sel, op_b_sel, imm_b_sel,
    output imm_i, imm_s, imm_b, imm_u, imm_j,
    output lsu_req_dec, branch_in_dec, jump_in_dec, rf_we_dec,
    input  instr_first_cycle
  );

  modport operand (
    input op_a_sel, op_b_sel, imm_b_sel,
    input imm_i, imm_s, imm_b, imm_u, imm_j
  );

  modport fsm (
    input  lsu_req_dec, branch_in_dec, jump_in_dec, rf_we_dec,
    output instr_first_cycle
  );

endinterface

/* id_decoder.sv */
/*
  RV32I decoder, purely combinational.
  illegal_insn_o is not qualified by instruction valid.
  Branches and jumps change their ALU setup after the first cycle.
*/

`timescale 1ns/1ps

module id_decoder import id_pkg::*; (
  input  instr_t          instr_rdata_i,
  output logic            illegal_insn_o,
  output reg_addr_t       rf_raddr_a_o,
  output reg_addr_t       rf_raddr_b_o,
  output reg_addr_t       rf_waddr_o,
  output logic            lsu_we_o,
  output lsu_type_t       lsu_type_o,
  output logic            lsu_sign_ext_o,
  id_ctrl_if.decoder      ctrl
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  alu_op_e    cmp_op;

  assign opcode = instr_rdata_i[6:0];
  assign funct3 = instr_rdata_i[14:12];
  assign funct7 = instr_rdata_i[31:25];

  // Register fields sit at fixed positions in every format
  assign rf_raddr_a_o = instr_rdata_i[19:15];
  assign rf_raddr_b_o = instr_rdata_i[24:20];
  assign rf_waddr_o   = instr_rdata_i[11:7];

  //////////////////////////////////////////////////
  // Immediates
  //////////////////////////////////////////////////

  assign ctrl.imm_i = {{20{instr_rdata_i[31]}}, instr_rdata_i[31:20]};
  assign ctrl.imm_s = {{20{instr_rdata_i[31]}}, instr_rdata_i[31:25], instr_rdata_i[11:7]};
  assign ctrl.imm_b = {{19{instr_rdata_i[31]}}, instr_rdata_i[31], instr_rdata_i[7],
                       instr_rdata_i[30:25], instr_rdata_i[11:8], 1'b0};
  assign ctrl.imm_u = {instr_rdata_i[31:12], 12'b0};
  assign ctrl.imm_j = {{12{instr_rdata_i[31]}}, instr_rdata_i[19:12], instr_rdata_i[20],
                       instr_rdata_i[30:21], 1'b0};

  //////////////////////////////////////////////////
  // Opcode decode
  //////////////////////////////////////////////////

  always_comb begin
    ctrl.alu_operator  = ALU_ADD;
    ctrl.op_a_sel      = OP_A_REG_A;
    ctrl.op_b_sel      = OP_B_REG_B;
    ctrl.imm_b_sel     = IMM_B_I;
    ctrl.lsu_req_dec   = 1'b0;
    ctrl.branch_in_dec = 1'b0;
    ctrl.jump_in_dec   = 1'b0;
    ctrl.rf_we_dec     = 1'b0;
    lsu_we_o           = 1'b0;
    lsu_type_o         = LSU_WORD;
    lsu_sign_ext_o     = 1'b0;
    illegal_insn_o     = 1'b0;
    cmp_op             = ALU_EQ;

    unique case (opcode)
      OPC_OP: begin
        ctrl.rf_we_dec = 1'b1;
        // Only funct7 of 0x00 and 0x20 exist in the base set
        unique case ({funct7, funct3})
          {7'h00, 3'b000}: ctrl.alu_operator = ALU_ADD;
          {7'h20, 3'b000}: ctrl.alu_operator = ALU_SUB;
          {7'h00, 3'b001}: ctrl.alu_operator = ALU_SLL;
          {7'h00, 3'b010}: ctrl.alu_operator = ALU_SLT;
          {7'h00, 3'b011}: ctrl.alu_operator = ALU_SLTU;
          {7'h00, 3'b100}: ctrl.alu_operator = ALU_XOR;
          {7'h00, 3'b101}: ctrl.alu_operator = ALU_SRL;
          {7'h20, 3'b101}: ctrl.alu_operator = ALU_SRA;
          {7'h00, 3'b110}: ctrl.alu_operator = ALU_OR;
          {7'h00, 3'b111}: ctrl.alu_operator = ALU_AND;
          default:         illegal_insn_o    = 1'b1;
        endcase
      end

      OPC_OP_IMM: begin
        ctrl.rf_we_dec = 1'b1;
        ctrl.op_b_sel  = OP_B_IMM;
        unique case (funct3)
          3'b000: ctrl.alu_operator = ALU_ADD;
          3'b010: ctrl.alu_operator = ALU_SLT;
          3'b011: ctrl.alu_operator = ALU_SLTU;
          3'b100: ctrl.alu_operator = ALU_XOR;
          3'b110: ctrl.alu_operator = ALU_OR;
          3'b111: ctrl.alu_operator = ALU_AND;
          3'b001: begin
            ctrl.alu_operator = ALU_SLL;
            illegal_insn_o    = (funct7 != 7'h00);
          end
          default: begin
            // Shift right, bit 30 picks arithmetic
            ctrl.alu_operator = funct7[5] ? ALU_SRA : ALU_SRL;
            illegal_insn_o    = (funct7 != 7'h00) && (funct7 != 7'h20);
          end
        endcase
      end

      OPC_LUI: begin
        ctrl.rf_we_dec = 1'b1;
        ctrl.op_a_sel  = OP_A_ZERO;
        ctrl.op_b_sel  = OP_B_IMM;
        ctrl.imm_b_sel = IMM_B_U;
      end

      OPC_AUIPC: begin
        ctrl.rf_we_dec = 1'b1;
        ctrl.op_a_sel  = OP_A_CURRPC;
        ctrl.op_b_sel  = OP_B_IMM;
        ctrl.imm_b_sel = IMM_B_U;
      end

      OPC_LOAD: begin
        // Address is rs1 plus I immediate
        ctrl.lsu_req_dec = 1'b1;
        ctrl.rf_we_dec   = 1'b1;
        ctrl.op_b_sel    = OP_B_IMM;
        lsu_sign_ext_o   = ~funct3[2];
        unique case (funct3)
          3'b000, 3'b100: lsu_type_o     = LSU_BYTE;
          3'b001, 3'b101: lsu_type_o     = LSU_HALF;
          3'b010:         lsu_type_o     = LSU_WORD;
          default:        illegal_insn_o = 1'b1;
        endcase
      end

      OPC_STORE: begin
        ctrl.lsu_req_dec = 1'b1;
        ctrl.op_b_sel    = OP_B_IMM;
        ctrl.imm_b_sel   = IMM_B_S;
        lsu_we_o         = 1'b1;
        unique case (funct3)
          3'b000:  lsu_type_o     = LSU_BYTE;
          3'b001:  lsu_type_o     = LSU_HALF;
          3'b010:  lsu_type_o     = LSU_WORD;
          default: illegal_insn_o = 1'b1;
        endcase
      end

      OPC_BRANCH: begin
        ctrl.branch_in_dec = 1'b1;
        unique case (funct3)
          3'b000:  cmp_op         = ALU_EQ;
          3'b001:  cmp_op         = ALU_NE;
          3'b100:  cmp_op         = ALU_LT;
          3'b101:  cmp_op         = ALU_GE;
          3'b110:  cmp_op         = ALU_LTU;
          3'b111:  cmp_op         = ALU_GEU;
          default: illegal_insn_o = 1'b1;
        endcase
        if (ctrl.instr_first_cycle) begin
          // Compare rs1 against rs2
          ctrl.alu_operator = cmp_op;
        end else begin
          // Target is PC plus B immediate
          ctrl.op_a_sel  = OP_A_CURRPC;
          ctrl.op_b_sel  = OP_B_IMM;
          ctrl.imm_b_sel = IMM_B_B;
        end
      end

      OPC_JAL, OPC_JALR: begin
        ctrl.jump_in_dec = 1'b1;
        ctrl.op_b_sel    = OP_B_IMM;
        illegal_insn_o   = (opcode == OPC_JALR) && (funct3 != 3'b000);
        if (ctrl.instr_first_cycle) begin
          // JAL target from PC, JALR target from rs1 plus I immediate
          if (opcode == OPC_JAL) begin
            ctrl.op_a_sel  = OP_A_CURRPC;
            ctrl.imm_b_sel = IMM_B_J;
          end
        end else begin
          // Link value written in the second cycle
          ctrl.op_a_sel  = OP_A_CURRPC;
          ctrl.imm_b_sel = IMM_B_INCR_PC;
          ctrl.rf_we_dec = 1'b1;
        end
      end

      default: illegal_insn_o = 1'b1;
    endcase
  end

endmodule

/* id_operand_mux.sv */
/*
  ALU operand selection for the decode stage.
  A misaligned second access overrides the decoded selects.
*/

`timescale 1ns/1ps

module id_operand_mux import id_pkg::*; (
  input  word_t        pc_id_i,
  input  word_t        rf_rdata_a_i,
  input  word_t        rf_rdata_b_i,
  input  word_t        lsu_addr_last_i,
  input  logic         lsu_addr_incr_req_i,
  output word_t        alu_operand_a_o,
  output word_t        alu_operand_b_o,
  id_ctrl_if.operand   ctrl
);

  op_a_sel_e  op_a_sel;
  op_b_sel_e  op_b_sel;
  imm_b_sel_e imm_b_sel;
  word_t      imm_b;

  // Second half of a misaligned access is last address plus one word
  assign op_a_sel  = lsu_addr_incr_req_i ? OP_A_LSU_ADDR   : ctrl.op_a_sel;
  assign op_b_sel  = lsu_addr_incr_req_i ? OP_B_IMM        : ctrl.op_b_sel;
  assign imm_b_sel = lsu_addr_incr_req_i ? IMM_B_INCR_ADDR : ctrl.imm_b_sel;

  //////////////////////////////////////////////////
  // Immediate select
  //////////////////////////////////////////////////

  always_comb begin
    unique case (imm_b_sel)
      IMM_B_I:         imm_b = ctrl.imm_i;
      IMM_B_S:         imm_b = ctrl.imm_s;
      IMM_B_B:         imm_b = ctrl.imm_b;
      IMM_B_U:         imm_b = ctrl.imm_u;
      IMM_B_J:         imm_b = ctrl.imm_j;
      IMM_B_INCR_PC:   imm_b = WORD_INCR;
      IMM_B_INCR_ADDR: imm_b = WORD_INCR;
      default:         imm_b = WORD_INCR;
    endcase
  end

  // Operand A
  always_comb begin
    unique case (op_a_sel)
      OP_A_REG_A:    alu_operand_a_o = rf_rdata_a_i;
      OP_A_LSU_ADDR: alu_operand_a_o = lsu_addr_last_i;
      OP_A_CURRPC:   alu_operand_a_o = pc_id_i;
      default:       alu_operand_a_o = '0;
    endcase
  end

  // Operand B
  assign alu_operand_b_o = (op_b_sel == OP_B_IMM) ? imm_b : rf_rdata_b_i;

endmodule

/* id_ex_fsm.sv */
/*
  ID-EX state machine for the two-stage pipeline.
  Loads, stores, taken branches and jumps take at least two cycles.
  An illegal instruction or a fetch error never executes.
*/

`timescale 1ns/1ps

module id_ex_fsm import id_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_ni,
  input  logic       instr_valid_i,
  input  logic       instr_fetch_err_i,
  input  logic       illegal_insn_i,
  input  logic       branch_decision_i,
  input  logic       ex_valid_i,
  input  logic       lsu_valid_i,
  input  logic       lsu_busy_i,
  output logic       lsu_req_o,
  output logic       branch_set_o,
  output logic       jump_set_o,
  output logic       rf_we_o,
  output logic       instr_id_done_o,
  id_ctrl_if.fsm     ctrl
);

  id_fsm_e id_fsm_q;
  id_fsm_e id_fsm_d;
  logic    branch_set_d;
  logic    instr_executing;
  logic    multicycle_done;
  logic    stall_mem;
  logic    stall_branch;
  logic    stall_jump;

  // Still first cycle while the instruction is held
  assign ctrl.instr_first_cycle = instr_valid_i & (id_fsm_q == FIRST_CYCLE);

  assign instr_executing = instr_valid_i & ~instr_fetch_err_i & ~illegal_insn_i;

  // First cycle of a memory access always stalls
  // Then wait for LSU response
  assign stall_mem = instr_valid_i &
                     (lsu_busy_i | (ctrl.lsu_req_dec & (~lsu_valid_i | ctrl.instr_first_cycle)));

  assign multicycle_done = ctrl.lsu_req_dec ? lsu_valid_i : ex_valid_i;

  //////////////////////////////////////////////////
  // Next state and stalls
  //////////////////////////////////////////////////

  always_comb begin
    id_fsm_d     = id_fsm_q;
    stall_branch = 1'b0;
    stall_jump   = 1'b0;
    branch_set_d = 1'b0;

    if (instr_executing) begin
      unique case (id_fsm_q)
        FIRST_CYCLE: begin
          if (ctrl.lsu_req_dec) begin
            id_fsm_d = MULTI_CYCLE;
          end else if (ctrl.branch_in_dec) begin
            // Taken branch needs a second cycle for the target
            id_fsm_d     = branch_decision_i ? MULTI_CYCLE : FIRST_CYCLE;
            stall_branch = branch_decision_i;
            branch_set_d = branch_decision_i;
          end else if (ctrl.jump_in_dec) begin
            id_fsm_d   = MULTI_CYCLE;
            stall_jump = 1'b1;
          end
        end
        MULTI_CYCLE: begin
          // Hold state under back-pressure
          if (multicycle_done & ~stall_mem) begin
            id_fsm_d = FIRST_CYCLE;
          end else begin
            stall_branch = ctrl.branch_in_dec;
            stall_jump   = ctrl.jump_in_dec;
          end
        end
        default: id_fsm_d = FIRST_CYCLE;
      endcase
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      id_fsm_q     <= FIRST_CYCLE;
      branch_set_o <= 1'b0;
    end else begin
      id_fsm_q     <= id_fsm_d;
      // Target is formed one cycle after the decision
      branch_set_o <= branch_set_d;
    end
  end

  //////////////////////////////////////////////////
  // Outputs
  //////////////////////////////////////////////////

  assign instr_id_done_o = instr_executing & ~(stall_mem | stall_branch | stall_jump);

  // Strobes only in the first executing cycle
  assign lsu_req_o  = instr_executing & ctrl.instr_first_cycle & ctrl.lsu_req_dec;
  assign jump_set_o = instr_executing & ctrl.instr_first_cycle & ctrl.jump_in_dec;

  assign rf_we_o = ctrl.rf_we_dec & instr_executing & instr_id_done_o;

endmodule

/* id_stage.sv */
/*
  RV32I decode stage top for a two-stage core.
  No forwarding, hazard stalls or controller; illegal encodings are only flagged.
  Store data comes straight from register file port B.
*/

`timescale 1ns/1ps

module id_stage import id_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_ni,

  // Instruction from IF-ID register
  input  logic      instr_valid_i,
  input  instr_t    instr_rdata_i,
  input  logic      instr_fetch_err_i,
  input  word_t     pc_id_i,

  // Register file
  output reg_addr_t rf_raddr_a_o,
  output reg_addr_t rf_raddr_b_o,
  input  word_t     rf_rdata_a_i,
  input  word_t     rf_rdata_b_i,
  output reg_addr_t rf_waddr_o,
  output logic      rf_we_o,

  // ALU
  output alu_op_e   alu_operator_o,
  output word_t     alu_operand_a_o,
  output word_t     alu_operand_b_o,

  // Execute and branch
  input  logic      branch_decision_i,
  input  logic      ex_valid_i,

  // LSU
  output logic      lsu_req_o,
  output logic      lsu_we_o,
  output lsu_type_t lsu_type_o,
  output logic      lsu_sign_ext_o,
  output word_t     lsu_wdata_o,
  input  logic      lsu_valid_i,
  input  logic      lsu_busy_i,
  input  logic      lsu_addr_incr_req_i,
  input  word_t     lsu_addr_last_i,

  // Status
  output logic      branch_set_o,
  output logic      jump_set_o,
  output logic      illegal_insn_o,
  output logic      instr_id_done_o
);

  id_ctrl_if i_ctrl_if ();

  assign alu_operator_o = i_ctrl_if.alu_operator;
  assign lsu_wdata_o    = rf_rdata_b_i;

  //////////////////////////////////////////////////
  // Decoder
  //////////////////////////////////////////////////

  id_decoder i_decoder (
    .instr_rdata_i  (instr_rdata_i),
    .illegal_insn_o (illegal_insn_o),
    .rf_raddr_a_o   (rf_raddr_a_o),
    .rf_raddr_b_o   (rf_raddr_b_o),
    .rf_waddr_o     (rf_waddr_o),
    .lsu_we_o       (lsu_we_o),
    .lsu_type_o     (lsu_type_o),
    .lsu_sign_ext_o (lsu_sign_ext_o),
    .ctrl           (i_ctrl_if)
  );

  // Operands
  id_operand_mux i_operand_mux (
    .pc_id_i             (pc_id_i),
    .rf_rdata_a_i        (rf_rdata_a_i),
    .rf_rdata_b_i        (rf_rdata_b_i),
    .lsu_addr_last_i     (lsu_addr_last_i),
    .lsu_addr_incr_req_i (lsu_addr_incr_req_i),
    .alu_operand_a_o     (alu_operand_a_o),
    .alu_operand_b_o     (alu_operand_b_o),
    .ctrl                (i_ctrl_if)
  );

  // ID-EX sequencing
  id_ex_fsm i_ex_fsm (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .instr_valid_i     (instr_valid_i),
    .instr_fetch_err_i (instr_fetch_err_i),
    .illegal_insn_i    (illegal_insn_o),
    .branch_decision_i (branch_decision_i),
    .ex_valid_i        (ex_valid_i),
    .lsu_valid_i       (lsu_valid_i),
    .lsu_busy_i        (lsu_busy_i),
    .lsu_req_o         (lsu_req_o),
    .branch_set_o      (branch_set_o),
    .jump_set_o        (jump_set_o),
    .rf_we_o           (rf_we_o),
    .instr_id_done_o   (instr_id_done_o),
    .ctrl              (i_ctrl_if)
  );

endmodule

/* id_stage_props.sv */
/*
  Timing rules of the ID-EX FSM.
  Bound into every id_ex_fsm instance.
*/

`timescale 1ns/1ps

module id_stage_props import id_pkg::*; (
  input logic    clk_i,
  input logic    rst_ni,
  input logic    branch_set_o,
  input logic    lsu_req_o,
  input logic    instr_id_done_o,
  input id_fsm_e id_fsm_q
);

  // Branch set is a single-cycle strobe
  a_branch_set_pulse: assert property (@(posedge clk_i) disable iff (!rst_ni)
    branch_set_o |=> !branch_set_o)
    else $error("branch_set_o held for two cycles");

  // LSU request always stalls into MULTI_CYCLE
  a_lsu_req_first: assert property (@(posedge clk_i) disable iff (!rst_ni)
    lsu_req_o |=> (id_fsm_q == MULTI_CYCLE))
    else $error("lsu_req_o not followed by MULTI_CYCLE");

  // A finished instruction returns the FSM to its first cycle
  a_done_first: assert property (@(posedge clk_i) disable iff (!rst_ni)
    instr_id_done_o |=> (id_fsm_q == FIRST_CYCLE))
    else $error("instr_id_done_o not followed by FIRST_CYCLE");

endmodule

bind id_ex_fsm id_stage_props i_props (
  .clk_i           (clk_i),
  .rst_ni          (rst_ni),
  .branch_set_o    (branch_set_o),
  .lsu_req_o       (lsu_req_o),
  .instr_id_done_o (instr_id_done_o),
  .id_fsm_q        (id_fsm_q)
);

/* id_checker.sv */
/*
  Response checker for the decode stage testbench.
  Expected values come from the RV32I encoding of the applied instruction.
  Driven by task calls from the testbench top at stable sample points.
*/

`timescale 1ns/1ps

module id_checker import id_pkg::*; (
  input instr_t    instr_i,
  input word_t     rdata_a_i,
  input word_t     rdata_b_i,
  input word_t     pc_i,
  input word_t     addr_last_i,
  input logic      incr_req_i,
  input reg_addr_t raddr_a_i,
  input reg_addr_t raddr_b_i,
  input reg_addr_t waddr_i,
  input alu_op_e   operator_i,
  input word_t     operand_a_i,
  input word_t     operand_b_i,
  input logic      lsu_we_i,
  input lsu_type_t lsu_type_i,
  input logic      lsu_sign_ext_i,
  input word_t     lsu_wdata_i,
  input logic      illegal_i
);

  int err_count  = 0;
  int pass_count = 0;
  int fail_count = 0;
  int errs_start = 0;

  // Immediates as the ISA defines them
  function automatic word_t imm_i_of(instr_t ins);
    return {{20{ins[31]}}, ins[31:20]};
  endfunction

  function automatic word_t imm_s_of(instr_t ins);
    return {{20{ins[31]}}, ins[31:25], ins[11:7]};
  endfunction

  function automatic word_t imm_b_of(instr_t ins);
    return {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
  endfunction

  function automatic word_t imm_j_of(instr_t ins);
    return {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
  endfunction

  // Operator from funct3, with bit 30 for SUB and SRA
  function automatic alu_op_e operator_of(instr_t ins);
    logic [2:0] f3;
    logic       alt;
    f3  = ins[14:12];
    alt = ins[30];
    if (ins[6:0] == OPC_BRANCH) begin
      case (f3)
        3'b000:  return ALU_EQ;
        3'b001:  return ALU_NE;
        3'b100:  return ALU_LT;
        3'b101:  return ALU_GE;
        3'b110:  return ALU_LTU;
        default: return ALU_GEU;
      endcase
    end
    if (ins[6:0] != OPC_OP && ins[6:0] != OPC_OP_IMM) begin
      return ALU_ADD;
    end
    case (f3)
      3'b000:  return (alt && ins[6:0] == OPC_OP) ? ALU_SUB : ALU_ADD;
      3'b001:  return ALU_SLL;
      3'b010:  return ALU_SLT;
      3'b011:  return ALU_SLTU;
      3'b100:  return ALU_XOR;
      3'b101:  return alt ? ALU_SRA : ALU_SRL;
      3'b110:  return ALU_OR;
      default: return ALU_AND;
    endcase
  endfunction

  task automatic check_field(input string name, input word_t got, input word_t exp);
    if (got !== exp) begin
      $display("FAILED %s: got %h expected %h", name, got, exp);
      err_count++;
    end
  endtask

  task automatic start_test();
    errs_start = err_count;
  endtask

  //////////////////////////////////////////////////
  // First cycle decode
  //////////////////////////////////////////////////

  task automatic check_first(input logic exp_illegal);
    word_t     exp_a;
    word_t     exp_b;
    lsu_type_t exp_type;
    logic [6:0] opc;
    opc   = instr_i[6:0];
    exp_a = rdata_a_i;
    exp_b = rdata_b_i;
    check_field("illegal_insn_o", 32'(illegal_i), 32'(exp_illegal));
    check_field("rf_raddr_a_o", 32'(raddr_a_i), 32'(instr_i[19:15]));
    check_field("rf_raddr_b_o", 32'(raddr_b_i), 32'(instr_i[24:20]));
    check_field("rf_waddr_o", 32'(waddr_i), 32'(instr_i[11:7]));
    if (!exp_illegal) begin
      case (opc)
        OPC_OP_IMM, OPC_LOAD, OPC_JALR: exp_b = imm_i_of(instr_i);
        OPC_STORE: exp_b = imm_s_of(instr_i);
        OPC_LUI: begin
          exp_a = '0;
          exp_b = {instr_i[31:12], 12'b0};
        end
        OPC_AUIPC: begin
          exp_a = pc_i;
          exp_b = {instr_i[31:12], 12'b0};
        end
        OPC_JAL: begin
          exp_a = pc_i;
          exp_b = imm_j_of(instr_i);
        end
        default: ;
      endcase
      // Second half of a misaligned access
      if (incr_req_i) begin
        exp_a = addr_last_i;
        exp_b = 32'd4;
      end
      check_field("alu_operand_a_o", operand_a_i, exp_a);
      check_field("alu_operand_b_o", operand_b_i, exp_b);
      check_field("alu_operator_o", 32'(operator_i), 32'(operator_of(instr_i)));
      if (opc == OPC_LOAD || opc == OPC_STORE) begin
        case (instr_i[13:12])
          2'b00:   exp_type = LSU_BYTE;
          2'b01:   exp_type = LSU_HALF;
          default: exp_type = LSU_WORD;
        endcase
        check_field("lsu_we_o", 32'(lsu_we_i), 32'(opc == OPC_STORE));
        check_field("lsu_type_o", 32'(lsu_type_i), 32'(exp_type));
        check_field("lsu_sign_ext_o", 32'(lsu_sign_ext_i),
                    32'(opc == OPC_LOAD && !instr_i[14]));
        check_field("lsu_wdata_o", lsu_wdata_i, rdata_b_i);
      end
    end
  endtask

  // Target cycle of a taken branch, link cycle of a jump
  task automatic check_second();
    check_field("alu_operand_a_o", operand_a_i, pc_i);
    if (instr_i[6:0] == OPC_BRANCH) begin
      check_field("alu_operand_b_o", operand_b_i, imm_b_of(instr_i));
    end else begin
      check_field("alu_operand_b_o", operand_b_i, 32'd4);
    end
  endtask

  task automatic finish_test(input int idx);
    if (err_count == errs_start) begin
      $display("test %0d instr %h: ok", idx, instr_i);
      pass_count++;
    end else begin
      $display("test %0d instr %h: %0d errors", idx, instr_i, err_count - errs_start);
      fail_count++;
    end
  endtask

endmodule

/* tb_id_stage.sv */
/*
  Testbench top for the decode stage.
  Stimulus table applied in a loop; LSU valid follows each entry's delay.
  EX is modelled as always valid and the LSU as never busy.
*/

`timescale 1ns/1ps

module tb_id_stage import id_pkg::*; ();

  localparam int NUM_TESTS = 19;
  localparam int TIMEOUT   = 12;

  typedef struct packed {
    instr_t     instr;
    logic       taken;
    logic       misal;
    logic       err;
    logic       ill;
    logic [3:0] delay;
  } entry_t;

  logic      clk_i;
  logic      rst_ni;
  logic      instr_valid, fetch_err, branch_decision, ex_valid;
  logic      lsu_valid, lsu_busy, incr_req;
  instr_t    instr;
  word_t     pc, rdata_a, rdata_b, addr_last;
  reg_addr_t raddr_a, raddr_b, waddr;
  logic      rf_we, lsu_req, lsu_we, lsu_sign_ext;
  logic      branch_set, jump_set, illegal, done;
  alu_op_e   alu_operator;
  word_t     operand_a, operand_b, lsu_wdata;
  lsu_type_t lsu_type;

  entry_t tests [NUM_TESTS];

  id_stage i_dut (
    .clk_i (clk_i), .rst_ni (rst_ni),
    .instr_valid_i (instr_valid), .instr_rdata_i (instr),
    .instr_fetch_err_i (fetch_err), .pc_id_i (pc),
    .rf_raddr_a_o (raddr_a), .rf_raddr_b_o (raddr_b),
    .rf_rdata_a_i (rdata_a), .rf_rdata_b_i (rdata_b),
    .rf_waddr_o (waddr), .rf_we_o (rf_we),
    .alu_operator_o (alu_operator), .alu_operand_a_o (operand_a),
    .alu_operand_b_o (operand_b),
    .branch_decision_i (branch_decision), .ex_valid_i (ex_valid),
    .lsu_req_o (lsu_req), .lsu_we_o (lsu_we), .lsu_type_o (lsu_type),
    .lsu_sign_ext_o (lsu_sign_ext), .lsu_wdata_o (lsu_wdata),
    .lsu_valid_i (lsu_valid), .lsu_busy_i (lsu_busy),
    .lsu_addr_incr_req_i (incr_req), .lsu_addr_last_i (addr_last),
    .branch_set_o (branch_set), .jump_set_o (jump_set),
    .illegal_insn_o (illegal), .instr_id_done_o (done)
  );

  id_checker i_chk (
    .instr_i (instr), .rdata_a_i (rdata_a), .rdata_b_i (rdata_b),
    .pc_i (pc), .addr_last_i (addr_last), .incr_req_i (incr_req),
    .raddr_a_i (raddr_a), .raddr_b_i (raddr_b), .waddr_i (waddr),
    .operator_i (alu_operator), .operand_a_i (operand_a),
    .operand_b_i (operand_b), .lsu_we_i (lsu_we), .lsu_type_i (lsu_type),
    .lsu_sign_ext_i (lsu_sign_ext), .lsu_wdata_i (lsu_wdata),
    .illegal_i (illegal)
  );

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  //////////////////////////////////////////////////
  // Stimulus table with columns instr, taken, misal, err, ill and delay
  //////////////////////////////////////////////////

  initial begin
    tests[0]  = '{32'h002081b3, 1'b0, 1'b0, 1'b0, 1'b0, 4'd0};
    tests[1]  = '{32'h407302b3, 1'b0, 1'b0, 1'b0, 1'b0, 4'd0};
    tests[2]  = '{32'h40325213, 1'b0, 1'b0, 1'b0, 1'b0, 4'd0};
    tests[3]  = '{32'hffb10093, 1'b0, 1'b0, 1'b0, 1'b0, 4'd0};
    tests[4]  = '{32'h123453b7, 1'b0, 1'b0, 1'b0, 1'b0, 4'd0};
    tests[5]  = '{32'habcde417, 1'b0, 1'b0, 1'b0, 1'b0, 4'd0};
    tests[6]  = '{32'hff852483, 1'b0, 1'b0, 1'b0, 1'b0, 4'd2};
    tests[7]  = '{32'h00364583, 1'b0, 1'b0, 1'b0, 1'b0, 4'd0};
    tests[8]  = '{32'hfed71f23, 1'b0, 1'b0, 1'b0, 1'b0, 4'd3};
    tests[9]  = '{32'h00208863, 1'b0, 1'b0, 1'b0, 1'b0, 4'd0};
    tests[10] = '{32'hfe419ce3, 1'b1, 1'b0, 1'b0, 1'b0, 4'd0};
    tests[11] = '{32'h0020c463, 1'b1, 1'b0, 1'b0, 1'b0, 4'd0};
    tests[12] = '{32'h100000ef, 1'b0, 1'b0, 1'b0, 1'b0, 4'd0};
    tests[13] = '{32'h00c302e7, 1'b0, 1'b0, 1'b0, 1'b0, 4'd0};
    tests[14] = '{32'hff852483, 1'b0, 1'b1, 1'b0, 1'b0, 4'd1};
    tests[15] = '{32'hffffffff, 1'b0, 1'b0, 1'b0, 1'b1, 4'd0};
    tests[16] = '{32'h022081b3, 1'b0, 1'b0, 1'b0, 1'b1, 4'd0};
    tests[17] = '{32'h002081b3, 1'b0, 1'b0, 1'b1, 1'b0, 4'd0};
    tests[18] = '{32'h00112023, 1'b0, 1'b0, 1'b1, 1'b0, 4'd0};
  end

  initial begin
    entry_t     e;
    logic [6:0] opc;
    logic       mem, multi, writes, quiet, done_seen;
    int         cyc, done_cyc, exp_cyc, n_req, n_bset, n_jset;
    void'($urandom(49370));
    rst_ni = 1'b0;
    instr_valid = 1'b0;
    fetch_err = 1'b0;
    branch_decision = 1'b0;
    ex_valid = 1'b0;
    lsu_valid = 1'b0;
    lsu_busy = 1'b0;
    incr_req = 1'b0;
    instr = '0;
    pc = '0;
    rdata_a = '0;
    rdata_b = '0;
    addr_last = '0;
    repeat (8) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;

    for (int i = 0; i < NUM_TESTS; i++) begin
      e = tests[i];
      opc = e.instr[6:0];
      mem = (opc == OPC_LOAD) || (opc == OPC_STORE);
      multi = (opc == OPC_JAL) || (opc == OPC_JALR) || (opc == OPC_BRANCH && e.taken);
      writes = !(opc == OPC_STORE || opc == OPC_BRANCH);
      quiet = e.ill || e.err;
      exp_cyc = mem ? 1 + int'(e.delay) : (multi ? 1 : 0);
      @(negedge clk_i);
      instr = e.instr;
      instr_valid = 1'b1;
      fetch_err = e.err;
      incr_req = e.misal;
      branch_decision = e.taken;
      ex_valid = 1'b1;
      lsu_valid = 1'b0;
      rdata_a = $urandom;
      rdata_b = $urandom;
      addr_last = $urandom;
      pc = $urandom & 32'hffff_fffc;
      i_chk.start_test();
      cyc = 0;
      done_cyc = 0;
      done_seen = 1'b0;
      n_req = 0;
      n_bset = 0;
      n_jset = 0;
      // Wait for done, one sample per cycle
      while (!done_seen && cyc < TIMEOUT) begin
        #5;
        if (cyc == 0) begin
          i_chk.check_first(e.ill);
          // Registered branch set stays low in the decision cycle
          i_chk.check_field("branch_set_o", 32'(branch_set), 32'd0);
        end else begin
          // Jump set belongs to the target cycle only
          i_chk.check_field("jump_set_o", 32'(jump_set), 32'd0);
          if (multi && !e.misal) begin
            i_chk.check_second();
          end
        end
        n_req += int'(lsu_req);
        n_bset += int'(branch_set);
        n_jset += int'(jump_set);
        if (done) begin
          done_seen = 1'b1;
          done_cyc = cyc;
          i_chk.check_field("rf_we_o", 32'(rf_we), 32'(writes));
          if (mem) begin
            i_chk.check_field("lsu_valid_i at done", 32'(lsu_valid), 32'd1);
          end
        end else begin
          i_chk.check_field("rf_we_o", 32'(rf_we), 32'd0);
        end
        @(negedge clk_i);
        cyc++;
        branch_decision = 1'b0;
        lsu_valid = (cyc >= 1 + int'(e.delay));
      end
      // Branch set registered in the last cycle of the instruction
      n_bset += int'(branch_set);
      instr_valid = 1'b0;
      lsu_valid = 1'b0;
      if (!quiet && !done_seen) begin
        $display("test %0d: instr_id_done_o did not rise within %0d cycles", i, TIMEOUT);
        $display("Testbench failed");
        $finish;
      end else begin
        if (quiet) begin
          i_chk.check_field("instr_id_done_o seen", 32'(done_seen), 32'd0);
        end else begin
          i_chk.check_field("done cycle", 32'(done_cyc), 32'(exp_cyc));
        end
        i_chk.check_field("lsu_req_o count", 32'(n_req), 32'(mem && !quiet));
        i_chk.check_field("branch_set_o count", 32'(n_bset),
                          32'(opc == OPC_BRANCH && e.taken && !quiet));
        i_chk.check_field("jump_set_o count", 32'(n_jset),
                          32'((opc == OPC_JAL || opc == OPC_JALR) && !quiet));
        i_chk.finish_test(i);
      end
    end

    $display("tests: %0d passed, %0d failed, %0d check errors",
             i_chk.pass_count, i_chk.fail_count, i_chk.err_count);
    if (i_chk.fail_count == 0 && i_chk.err_count == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

/* src.f */
id_pkg.sv
id_ctrl_if.sv
id_decoder.sv
id_operand_mux.sv
id_ex_fsm.sv
id_stage.sv
id_stage_props.sv
id_checker.sv
tb_id_stage.sv

/* Makefile */
SRCS := $(wildcard *.sv)

.PHONY: all run clean

all: run

obj_dir/Vtb_id_stage: $(SRCS) src.f
	verilator --binary --timing --assert -f src.f --top-module tb_id_stage -o Vtb_id_stage

run: obj_dir/Vtb_id_stage
	./obj_dir/Vtb_id_stage > sim.log 2>&1 || (cat sim.log; exit 1)
	cat sim.log
	! grep -q "Testbench failed" sim.log

clean:
	rm -rf obj_dir sim.log
